/* build.f */
src/sort_shim_pkg.sv
src/req_buffer.sv
src/rd_scoreboard.sv
src/sort_responses.sv
src/sort_shim_top.sv
verification/sort_shim_props.sv
verification/tb_sort_shim.sv

/* Bender.yml */
package:
  name: sort_shim

sources:
  # Package first, then the RTL from the leaves up to the top level
  - src/sort_shim_pkg.sv
  - src/req_buffer.sv
  - src/rd_scoreboard.sv
  - src/sort_responses.sv
  - src/sort_shim_top.sv

  # Bound checks and the testbench
  - target: test
    files:
      - verification/sort_shim_props.sv
      - verification/tb_sort_shim.sv

/* verification/tb_sort_shim.sv */
// Self-checking testbench for the sorting shim with random AFU traffic and an out-of-order platform
`timescale 1ns/1ns
`default_nettype none

module tb_sort_shim
    import sort_shim_pkg::*;
();

    localparam int n_req      = 400;
    localparam int n_sb       = 16;
    localparam int n_buf      = 4;
    localparam int clk_period = 20;

    // Issued request tagged with the edge that writes it into the request buffer
    typedef struct packed {
        logic [31:0] edge_no;
        rd_req_t     req;
    } rd_log_t;

    typedef struct packed {
        logic [31:0] edge_no;
        wr_req_t     req;
    } wr_log_t;

    // Write response waiting in the platform model until its edge comes up
    typedef struct packed {
        logic [31:0]        due;
        logic [mdata_w-1:0] mdata;
    } wr_due_t;

    logic    clk;
    logic    rst_n;
    logic    afu_c0_tx_valid;
    rd_req_t afu_c0_tx;
    logic    afu_c0_tx_alm_full;
    logic    afu_c1_tx_valid;
    wr_req_t afu_c1_tx;
    logic    afu_c1_tx_alm_full;
    logic    afu_c0_rx_valid;
    rd_rsp_t afu_c0_rx;
    logic    afu_c1_rx_valid;
    wr_rsp_t afu_c1_rx;
    logic    plat_c0_tx_valid;
    rd_req_t plat_c0_tx;
    logic    plat_c0_tx_alm_full;
    logic    plat_c1_tx_valid;
    wr_req_t plat_c1_tx;
    logic    plat_c1_tx_alm_full;
    logic    plat_c0_rx_valid;
    rd_rsp_t plat_c0_rx;
    logic    plat_c1_rx_valid;
    wr_rsp_t plat_c1_rx;

    integer             seed = 32'hda9a;
    int                 edge_no = 0;
    int                 issued = 0;
    int                 max_pool = 0;
    int                 hold_timer = 0;
    logic               holding = 1'b0;
    logic               rst_was_low = 1'b0;
    logic [31:0]        last_due = '0;
    logic [mdata_w-1:0] rd_tag = '0;

    // Order logs from AFU issue to the platform, per channel
    rd_log_t            rd_fwd_q[$];
    wr_log_t            wr_fwd_q[$];
    // Reads still owed to the AFU, in issue order
    rd_req_t            rd_exp_q[$];
    // Reads the platform holds, tagged with their slot index
    rd_req_t            pool[$];
    wr_due_t            wr_pend_q[$];
    logic [mdata_w-1:0] wr_rsp_q[$];

    sort_shim_top #(
        .n_sb_entries (n_sb),
        .buf_depth    (n_buf)
    ) i_sort_shim_top (.*);

    // Reference contents of a memory line depend on every address bit
    function automatic logic [data_w-1:0] line_data(input logic [addr_w-1:0] addr);
        return {addr * 32'h9e37_79b9, addr ^ 32'hc3a5_96f0};
    endfunction

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string test, input logic [127:0] expected,
                                   input logic [127:0] actual);
        end_with_failure($sformatf("MISMATCH %s expected %0h actual %0h", test, expected, actual));
    endtask

    function automatic logic all_done();
        return issued == n_req && rd_fwd_q.size() == 0 && wr_fwd_q.size() == 0 &&
               rd_exp_q.size() == 0 && pool.size() == 0 && wr_pend_q.size() == 0 &&
               wr_rsp_q.size() == 0;
    endfunction

    // AFU issues reads and writes with random gaps, never while its buffer is almost full
    task automatic drive_afu();
        int rd_roll;
        int wr_roll;
        afu_c0_tx_valid = 1'b0;
        afu_c1_tx_valid = 1'b0;
        rd_roll = $unsigned($random(seed)) % 8;
        wr_roll = $unsigned($random(seed)) % 8;
        if (issued < n_req && rd_roll < 3 && !afu_c0_tx_alm_full) begin
            afu_c0_tx_valid = 1'b1;
            afu_c0_tx.addr  = $random(seed);
            afu_c0_tx.mdata = rd_tag;
            rd_tag          = rd_tag + 1'b1;
            rd_fwd_q.push_back({32'(edge_no), afu_c0_tx});
            rd_exp_q.push_back(afu_c0_tx);
            issued++;
        end
        if (issued < n_req && wr_roll < 3 && !afu_c1_tx_alm_full) begin
            afu_c1_tx_valid = 1'b1;
            afu_c1_tx.addr  = $random(seed);
            afu_c1_tx.mdata = mdata_w'($random(seed));
            afu_c1_tx.data  = {$random(seed), $random(seed)};
            wr_fwd_q.push_back({32'(edge_no), afu_c1_tx});
            issued++;
        end
    endtask

    // Platform returns one random read per cycle unless it is holding to fill every slot
    task automatic drive_platform();
        int k;
        plat_c0_rx_valid    = 1'b0;
        plat_c1_rx_valid    = 1'b0;
        plat_c0_tx_alm_full = ($unsigned($random(seed)) % 4) == 0;
        plat_c1_tx_alm_full = ($unsigned($random(seed)) % 4) == 0;
        // A hold starts from an empty pool so that older returned slots drain first
        if (holding) begin
            if (pool.size() == n_sb || hold_timer == 0) begin
                holding = 1'b0;
            end else begin
                hold_timer--;
            end
        end else if (pool.size() == 0 && ($unsigned($random(seed)) % 40) == 0) begin
            holding    = 1'b1;
            hold_timer = 200;
        end
        if (!holding && pool.size() != 0) begin
            k = $unsigned($random(seed)) % pool.size();
            plat_c0_rx_valid = 1'b1;
            plat_c0_rx.mdata = pool[k].mdata;
            plat_c0_rx.data  = line_data(pool[k].addr);
            pool.delete(k);
        end
        if (wr_pend_q.size() != 0 && wr_pend_q[0].due <= edge_no) begin
            plat_c1_rx_valid = 1'b1;
            plat_c1_rx.mdata = wr_pend_q[0].mdata;
            wr_rsp_q.push_back(wr_pend_q[0].mdata);
            void'(wr_pend_q.pop_front());
        end
    endtask

    // ====================
    // Clock, reset, stimulus
    // ====================

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin : main
        rst_n               = 1'b0;
        afu_c0_tx_valid     = 1'b0;
        afu_c0_tx           = '0;
        afu_c1_tx_valid     = 1'b0;
        afu_c1_tx           = '0;
        plat_c0_tx_alm_full = 1'b0;
        plat_c1_tx_alm_full = 1'b0;
        plat_c0_rx_valid    = 1'b0;
        plat_c0_rx          = '0;
        plat_c1_rx_valid    = 1'b0;
        plat_c1_rx          = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (!all_done()) begin
            @(negedge clk);
            drive_afu();
            drive_platform();
        end
        // A few quiet cycles catch any response that should not exist
        repeat (10) @(negedge clk);
        if (max_pool < n_sb) begin
            end_with_failure("the scoreboard never had all 16 slots outstanding");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // Budget of 40 cycles per request
    initial begin : watchdog
        #(n_req * 40 * clk_period);
        end_with_failure($sformatf("timeout with %0d of %0d requests issued", issued, n_req));
    end

    // ====================
    // Compare
    // ====================

    // Sampled at the rising edge, half a cycle after the inputs settled
    always @(posedge clk) begin : compare
        rd_log_t            exp_rd;
        wr_log_t            exp_wr;
        rd_req_t            exp_rsp;
        logic [mdata_w-1:0] exp_wmd;
        logic [31:0]        due;
        int                 rd_held;
        int                 wr_held;
        logic               exp_c0_full;
        logic               exp_c1_full;
        if (rst_was_low) begin
            assert (!(afu_c0_rx_valid || afu_c1_rx_valid || plat_c0_tx_valid ||
                      plat_c1_tx_valid || afu_c0_tx_alm_full || afu_c1_tx_alm_full))
            else end_with_failure("a valid or almost-full output was high right after reset");
        end
        if (rst_n) begin
            // Requests written at earlier edges and not yet forwarded still sit in the buffers
            rd_held = 0;
            wr_held = 0;
            foreach (rd_fwd_q[i]) begin
                if (rd_fwd_q[i].edge_no < edge_no) begin
                    rd_held++;
                end
            end
            foreach (wr_fwd_q[i]) begin
                if (wr_fwd_q[i].edge_no < edge_no) begin
                    wr_held++;
                end
            end
            // Almost full means at most one free entry left
            exp_c0_full = (n_buf - rd_held) <= 1;
            exp_c1_full = (n_buf - wr_held) <= 1;
            assert (afu_c0_tx_alm_full == exp_c0_full)
            else report_mismatch("c0_alm_full", 128'(exp_c0_full), 128'(afu_c0_tx_alm_full));
            assert (afu_c1_tx_alm_full == exp_c1_full)
            else report_mismatch("c1_alm_full", 128'(exp_c1_full), 128'(afu_c1_tx_alm_full));
            if (plat_c0_tx_valid) begin
                assert (!plat_c0_tx_alm_full)
                else end_with_failure("read sent while platform channel 0 was almost full");
            end
            if (plat_c1_tx_valid) begin
                assert (!plat_c1_tx_alm_full)
                else end_with_failure("write sent while platform channel 1 was almost full");
            end
            // A channel never moves alone while the other has a request at its head
            if (plat_c0_tx_valid && !plat_c1_tx_valid && wr_fwd_q.size() != 0) begin
                assert (wr_fwd_q[0].edge_no >= edge_no)
                else end_with_failure("a read reached the platform ahead of a waiting write");
            end
            if (plat_c1_tx_valid && !plat_c0_tx_valid && rd_fwd_q.size() != 0) begin
                assert (rd_fwd_q[0].edge_no >= edge_no)
                else end_with_failure("a write reached the platform ahead of a waiting read");
            end
            if (plat_c0_tx_valid) begin
                assert (rd_fwd_q.size() != 0)
                else end_with_failure("platform received a read that was never issued");
                exp_rd = rd_fwd_q.pop_front();
                assert (plat_c0_tx.addr == exp_rd.req.addr)
                else report_mismatch("read_forward", 128'(exp_rd.req.addr), 128'(plat_c0_tx.addr));
                assert (pool.size() < n_sb && plat_c0_tx.mdata < n_sb)
                else end_with_failure("more than 16 reads outstanding or a bad slot index");
                foreach (pool[i]) begin
                    assert (pool[i].mdata != plat_c0_tx.mdata)
                    else end_with_failure("slot index reused while still outstanding");
                end
                pool.push_back(plat_c0_tx);
                if (pool.size() > max_pool) begin
                    max_pool = pool.size();
                end
            end
            if (plat_c1_tx_valid) begin
                assert (wr_fwd_q.size() != 0)
                else end_with_failure("platform received a write that was never issued");
                exp_wr = wr_fwd_q.pop_front();
                assert (plat_c1_tx == exp_wr.req)
                else report_mismatch("write_pass", 128'(exp_wr.req), 128'(plat_c1_tx));
                // Responses keep write order, so a due edge never goes backwards
                due = edge_no + 1 + $unsigned($random(seed)) % 6;
                if (due < last_due) begin
                    due = last_due;
                end
                last_due = due;
                wr_pend_q.push_back({due, plat_c1_tx.mdata});
            end
            if (afu_c0_rx_valid) begin
                assert (rd_exp_q.size() != 0)
                else end_with_failure("read response with no read outstanding");
                exp_rsp = rd_exp_q.pop_front();
                assert (afu_c0_rx.mdata == exp_rsp.mdata)
                else report_mismatch("read_order", 128'(exp_rsp.mdata), 128'(afu_c0_rx.mdata));
                assert (afu_c0_rx.data == line_data(exp_rsp.addr))
                else report_mismatch("read_data", 128'(line_data(exp_rsp.addr)),
                                     128'(afu_c0_rx.data));
            end
            assert (afu_c1_rx_valid == (wr_rsp_q.size() != 0))
            else end_with_failure("write response lost or invented on the AFU side");
            if (afu_c1_rx_valid) begin
                exp_wmd = wr_rsp_q.pop_front();
                assert (afu_c1_rx.mdata == exp_wmd)
                else report_mismatch("write_rsp", 128'(exp_wmd), 128'(afu_c1_rx.mdata));
            end
        end
        rst_was_low = !rst_n;
        edge_no++;
    end

endmodule

`default_nettype wire

/* verification/sort_shim_props.sv */
// Concurrent checks on the shim top-level ports, bound to every sort_shim_top instance
`timescale 1ns/1ns
`default_nettype none

module sort_shim_props (
    input logic clk,
    input logic rst_n,
    input logic afu_c0_tx_alm_full,
    input logic afu_c1_tx_alm_full,
    input logic afu_c0_rx_valid,
    input logic afu_c1_rx_valid,
    input logic plat_c0_tx_valid,
    input logic plat_c0_tx_alm_full,
    input logic plat_c1_tx_valid,
    input logic plat_c1_tx_alm_full
);

    // ====================
    // Platform back-pressure
    // ====================

    // The platform never sees a read while it signals almost full on channel 0
    c0_tx_obeys_alm_full: assert property (
        @(posedge clk) disable iff (!rst_n) plat_c0_tx_valid |-> !plat_c0_tx_alm_full
    ) else $error("read request sent while platform channel 0 was almost full");

    // Same rule for writes on channel 1
    c1_tx_obeys_alm_full: assert property (
        @(posedge clk) disable iff (!rst_n) plat_c1_tx_valid |-> !plat_c1_tx_alm_full
    ) else $error("write request sent while platform channel 1 was almost full");

    // ====================
    // Reset state
    // ====================

    // Every valid output is quiet in the cycle after a reset edge
    quiet_after_reset: assert property (
        @(posedge clk) !rst_n |=>
            !(afu_c0_rx_valid || afu_c1_rx_valid || plat_c0_tx_valid || plat_c1_tx_valid)
    ) else $error("valid output high in the cycle after reset");

    // Empty buffers leave room for the AFU
    alm_full_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !afu_c0_tx_alm_full && !afu_c1_tx_alm_full
    ) else $error("AFU almost-full output high in the cycle after reset");

endmodule

bind sort_shim_top sort_shim_props i_sort_shim_props (
    .clk                 (clk),
    .rst_n               (rst_n),
    .afu_c0_tx_alm_full  (afu_c0_tx_alm_full),
    .afu_c1_tx_alm_full  (afu_c1_tx_alm_full),
    .afu_c0_rx_valid     (afu_c0_rx_valid),
    .afu_c1_rx_valid     (afu_c1_rx_valid),
    .plat_c0_tx_valid    (plat_c0_tx_valid),
    .plat_c0_tx_alm_full (plat_c0_tx_alm_full),
    .plat_c1_tx_valid    (plat_c1_tx_valid),
    .plat_c1_tx_alm_full (plat_c1_tx_alm_full)
);

`default_nettype wire

/* src/sort_shim_top.sv */
// Top level of the response-sorting shim between the AFU request ports and the platform port
`timescale 1ns/1ns
`default_nettype none

module sort_shim_top
    import sort_shim_pkg::*;
#(
    parameter int n_sb_entries = 16,
    parameter int buf_depth    = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    // AFU side
    input  logic    afu_c0_tx_valid,
    input  rd_req_t afu_c0_tx,
    output logic    afu_c0_tx_alm_full,
    input  logic    afu_c1_tx_valid,
    input  wr_req_t afu_c1_tx,
    output logic    afu_c1_tx_alm_full,
    output logic    afu_c0_rx_valid,
    output rd_rsp_t afu_c0_rx,
    output logic    afu_c1_rx_valid,
    output wr_rsp_t afu_c1_rx,
    // Platform side
    output logic    plat_c0_tx_valid,
    output rd_req_t plat_c0_tx,
    input  logic    plat_c0_tx_alm_full,
    output logic    plat_c1_tx_valid,
    output wr_req_t plat_c1_tx,
    input  logic    plat_c1_tx_alm_full,
    input  logic    plat_c0_rx_valid,
    input  rd_rsp_t plat_c0_rx,
    input  logic    plat_c1_rx_valid,
    input  wr_rsp_t plat_c1_rx
);

    // Buffer heads and dequeue strobes
    logic    c0_not_empty;
    rd_req_t c0_first;
    logic    c0_deq;
    logic    c1_not_empty;
    wr_req_t c1_first;
    logic    c1_deq;

    // Read requests from the AFU
    req_buffer #(
        .entry_w   ($bits(rd_req_t)),
        .buf_depth (buf_depth)
    ) c0_buf (
        .clk,
        .rst_n,
        .enq_valid (afu_c0_tx_valid),
        .enq_data  (afu_c0_tx),
        .alm_full  (afu_c0_tx_alm_full),
        .deq       (c0_deq),
        .not_empty (c0_not_empty),
        .first     (c0_first)
    );

    // Write requests from the AFU
    req_buffer #(
        .entry_w   ($bits(wr_req_t)),
        .buf_depth (buf_depth)
    ) c1_buf (
        .clk,
        .rst_n,
        .enq_valid (afu_c1_tx_valid),
        .enq_data  (afu_c1_tx),
        .alm_full  (afu_c1_tx_alm_full),
        .deq       (c1_deq),
        .not_empty (c1_not_empty),
        .first     (c1_first)
    );

    sort_responses #(
        .n_sb_entries(n_sb_entries)
    ) sorter (
        .clk,
        .rst_n,
        .c0_not_empty,
        .c0_first,
        .c1_not_empty,
        .c1_first,
        .c0_deq,
        .c1_deq,
        .plat_c0_tx_alm_full,
        .plat_c1_tx_alm_full,
        .plat_c0_tx_valid,
        .plat_c0_tx,
        .plat_c1_tx_valid,
        .plat_c1_tx,
        .plat_c0_rx_valid,
        .plat_c0_rx,
        .afu_c0_rx_valid,
        .afu_c0_rx
    );

    // Write responses are not sorted and reach the AFU in the same cycle
    assign afu_c1_rx_valid = plat_c1_rx_valid;
    assign afu_c1_rx       = plat_c1_rx;

endmodule

`default_nettype wire

/* src/sort_responses.sv */
// Request gating across both channels and read response sorting between buffers and platform
`timescale 1ns/1ns
`default_nettype none

module sort_responses
    import sort_shim_pkg::*;
#(
    parameter int n_sb_entries = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    // Heads of the request buffers
    input  logic    c0_not_empty,
    input  rd_req_t c0_first,
    input  logic    c1_not_empty,
    input  wr_req_t c1_first,
    output logic    c0_deq,
    output logic    c1_deq,
    // Platform ports
    input  logic    plat_c0_tx_alm_full,
    input  logic    plat_c1_tx_alm_full,
    output logic    plat_c0_tx_valid,
    output rd_req_t plat_c0_tx,
    output logic    plat_c1_tx_valid,
    output wr_req_t plat_c1_tx,
    input  logic    plat_c0_rx_valid,
    input  rd_rsp_t plat_c0_rx,
    // Sorted read responses toward the AFU
    output logic    afu_c0_rx_valid,
    output rd_rsp_t afu_c0_rx
);

    localparam int idx_w = slot_idx_w(n_sb_entries);

    // Scoreboard state seen by the request logic
    logic             sb_not_full;
    logic [idx_w-1:0] sb_alloc_idx;

    logic c0_blocked;
    logic c1_blocked;
    logic process_requests;

    // ====================
    // Request gating
    // ====================

    // A read head is stuck if the platform is almost full or no slot is free
    assign c0_blocked = c0_not_empty && (plat_c0_tx_alm_full || !sb_not_full);

    // A write head only waits on the platform
    assign c1_blocked = c1_not_empty && plat_c1_tx_alm_full;

    // Move requests only when no pending head is stuck
    // Both channels advance together, which keeps reads and writes in issue order
    assign process_requests = (c0_not_empty || c1_not_empty) && !(c0_blocked || c1_blocked);

    assign c0_deq = process_requests && c0_not_empty;
    assign c1_deq = process_requests && c1_not_empty;

    // ====================
    // Channel 0, reads
    // ====================

    assign plat_c0_tx_valid = c0_deq;

    // The platform sees the slot index in place of the AFU tag
    always_comb begin
        plat_c0_tx       = c0_first;
        plat_c0_tx.mdata = mdata_w'(sb_alloc_idx);
    end

    // The tag comes back from the platform unchanged, so its low bits name the slot
    rd_scoreboard #(
        .n_sb_entries(n_sb_entries)
    ) c0_scoreboard (
        .clk,
        .rst_n,
        .alloc         (c0_deq),
        .alloc_mdata   (c0_first.mdata),
        .not_full      (sb_not_full),
        .alloc_idx     (sb_alloc_idx),
        .fill          (plat_c0_rx_valid),
        .fill_idx      (plat_c0_rx.mdata[idx_w-1:0]),
        .fill_data     (plat_c0_rx.data),
        .release_valid (afu_c0_rx_valid),
        .release_rsp   (afu_c0_rx)
    );

    // ====================
    // Channel 1, writes
    // ====================

    // Writes keep their own tag and data, they only wait for the joint gate
    assign plat_c1_tx_valid = c1_deq;
    assign plat_c1_tx       = c1_first;

endmodule

`default_nettype wire

/* src/rd_scoreboard.sv */
// Read scoreboard that swaps AFU metadata for slot indices and releases out-of-order data in order
`timescale 1ns/1ns
`default_nettype none

module rd_scoreboard
    import sort_shim_pkg::*;
#(
    parameter int n_sb_entries = 16
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Slot allocation as a read request leaves for the platform
    input  logic                                 alloc,
    input  logic [mdata_w-1:0]                   alloc_mdata,
    output logic                                 not_full,
    output logic [slot_idx_w(n_sb_entries)-1:0]  alloc_idx,
    // Platform data, arriving in any slot order
    input  logic                                 fill,
    input  logic [slot_idx_w(n_sb_entries)-1:0]  fill_idx,
    input  logic [data_w-1:0]                    fill_data,
    // Responses toward the AFU in allocation order
    output logic                                 release_valid,
    output rd_rsp_t                              release_rsp
);

    localparam int idx_w = slot_idx_w(n_sb_entries);
    localparam int cnt_w = $clog2(n_sb_entries + 1);

    typedef logic [idx_w-1:0] idx_t;

    // ====================
    // Slot state
    // ====================

    // Original AFU metadata, one per slot
    logic [mdata_w-1:0] meta_mem [n_sb_entries];

    // Returned line data, one per slot
    logic [data_w-1:0] data_mem [n_sb_entries];

    // Set once the platform has returned data for a slot
    logic [n_sb_entries-1:0] ready;

    // Next slot to hand out and oldest slot still outstanding
    idx_t newest;
    idx_t oldest;

    // Number of slots currently in use
    logic [cnt_w-1:0] count;

    // The oldest slot has its data and leaves at the next edge
    logic release_now;

    assign release_now = ready[oldest];
    assign not_full    = (count != cnt_w'(n_sb_entries));
    assign alloc_idx   = newest;

    // ====================
    // Control
    // ====================

    // Slots are handed out circularly, so the pointers wrap on their own
    // because the slot count is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            newest        <= '0;
            oldest        <= '0;
            count         <= '0;
            ready         <= '0;
            release_valid <= 1'b0;
        end else begin
            release_valid <= release_now;
            if (alloc) begin
                newest <= newest + 1'b1;
            end
            // Free the oldest slot as its response goes out
            if (release_now) begin
                ready[oldest] <= 1'b0;
                oldest        <= oldest + 1'b1;
            end
            // A slot that fills is never the one being freed in the same cycle
            if (fill) begin
                ready[fill_idx] <= 1'b1;
            end
            case ({alloc, release_now})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ====================
    // Payload
    // ====================

    // Metadata is written at allocation and data at fill
    // The released response is rebuilt from both copies of the oldest slot
    always_ff @(posedge clk) begin
        if (alloc) begin
            meta_mem[newest] <= alloc_mdata;
        end
        if (fill) begin
            data_mem[fill_idx] <= fill_data;
        end
        if (release_now) begin
            release_rsp.mdata <= meta_mem[oldest];
            release_rsp.data  <= data_mem[oldest];
        end
    end

endmodule

`default_nettype wire

/* src/req_buffer.sv */
// Circular request FIFO for one AFU channel; the AFU enqueues and the sorter dequeues explicitly
`timescale 1ns/1ns
`default_nettype none

module req_buffer #(
    parameter int entry_w   = 40,
    parameter int buf_depth = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    // AFU side, written whenever the valid strobe is high
    input  logic               enq_valid,
    input  logic [entry_w-1:0] enq_data,
    output logic               alm_full,
    // Sorter side, head is presented without a register stage
    input  logic               deq,
    output logic               not_empty,
    output logic [entry_w-1:0] first
);

    localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int cnt_w = $clog2(buf_depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;

    // Storage for the queued requests
    logic [entry_w-1:0] mem [buf_depth];

    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    logic [cnt_w-1:0] count;

    // Advance a pointer and wrap at the last entry
    // The depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        ptr_t nxt;
        if (p == ptr_t'(buf_depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = p + 1'b1;
        end
        return nxt;
    endfunction

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            // The sorter only dequeues while not_empty is high
            if (deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({enq_valid, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (enq_valid) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Head of the queue goes straight to the sorter
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Raised with one or no free entries, leaving room for a request already in flight
    assign alm_full = (count >= cnt_w'(buf_depth - 1));

endmodule

`default_nettype wire

/* src/sort_shim_pkg.sv */
// Shared field widths, request and response structs and slot helper; imported by the shim RTL
`default_nettype none

package sort_shim_pkg;

    // ====================
    // Field widths
    // ====================

    // Width of a line address as seen by both the AFU and the platform
    localparam int addr_w = 32;

    // Width of the AFU metadata tag carried with every request and response
    localparam int mdata_w = 8;

    // Width of one data line
    localparam int data_w = 64;

    // ====================
    // Channel payloads
    // ====================

    // Read request on channel 0, 40 bits
    typedef struct packed {
        logic [addr_w-1:0]  addr;
        logic [mdata_w-1:0] mdata;
    } rd_req_t;

    // Write request on channel 1, 104 bits
    typedef struct packed {
        logic [addr_w-1:0]  addr;
        logic [mdata_w-1:0] mdata;
        logic [data_w-1:0]  data;
    } wr_req_t;

    // Read response on channel 0, 72 bits
    typedef struct packed {
        logic [mdata_w-1:0] mdata;
        logic [data_w-1:0]  data;
    } rd_rsp_t;

    // Write response on channel 1, metadata only
    typedef struct packed {
        logic [mdata_w-1:0] mdata;
    } wr_rsp_t;

    // ====================
    // Helpers
    // ====================

    // Number of bits in a scoreboard slot index
    // A single-entry scoreboard still gets a one bit index so that ports stay legal
    function automatic int slot_idx_w(input int n_entries);
        int w;
        w = (n_entries > 1) ? $clog2(n_entries) : 1;
        return w;
    endfunction

endpackage

`default_nettype wire
